//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------

    localparam int WB_DEPTH_LOG2 = 2;
    localparam int WB_DEPTH = 1 << WB_DEPTH_LOG2;    // Buffer slots.

    localparam int NUM_BANKS = 4;
    localparam int BANK_BITS = 2;
    localparam int BANK_LSB = 2;                     // Bank index is addr[3:2].

    // Word index sits above the bank bits.
    localparam int BANK_WORDS_LOG2 = 6;
    localparam int BANK_WORDS = 1 << BANK_WORDS_LOG2;

    localparam int BANK_LATENCY = 2;                 // Accept to response, in cycles.

    // ------------------------------------------------------------
    // Port words
    // ------------------------------------------------------------

    // Request. Zero strobe with valid is a load, fence overrides both.
    typedef struct packed {
        logic        valid;
        logic        fence;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    // Response. Ready is a single-cycle pulse.
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // ------------------------------------------------------------
    // Write buffer slot
    // ------------------------------------------------------------

    // 68 bits, strobe on top.
    typedef struct packed {
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } wb_entry_t;

endpackage

`default_nettype wire

//--- design/write_buffer.sv
`default_nettype none

module write_buffer (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t core_req,
    output mem_pkg::mem_rsp_t core_rsp,
    output mem_pkg::mem_req_t dmem_req,
    input  mem_pkg::mem_rsp_t dmem_rsp
);

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------

    mem_pkg::wb_entry_t queue [mem_pkg::WB_DEPTH];

    logic [mem_pkg::WB_DEPTH_LOG2-1:0] wr_ptr;
    logic [mem_pkg::WB_DEPTH_LOG2-1:0] rd_ptr;
    logic                              wrap;       // Write side is one lap ahead.

    logic              busy;                       // One memory request in flight.
    logic              out_queue;                  // In-flight request is the head slot.
    logic              out_core;                   // In-flight request is a load or fence.
    logic              store_ack;
    mem_pkg::mem_req_t hold;                       // Core operation waiting its turn.
    mem_pkg::mem_req_t dmem_q;

    // ------------------------------------------------------------
    // Decisions
    // ------------------------------------------------------------

    mem_pkg::mem_req_t op;
    logic              op_store;
    logic              op_order;
    logic              empty;
    logic              full;
    logic              pop;
    logic              push;
    logic              bypass;
    logic              issue_head;
    logic              issue_op;
    logic              op_done;
    logic              issue;

    always_comb begin
        // A fresh request wins, the core never has two open.
        op = core_req.valid ? core_req : hold;

        op_store = op.valid && !op.fence && (op.wstrb != 4'b0000);
        op_order = op.valid && !op_store;          // Load or fence.

        empty = (wr_ptr == rd_ptr) && !wrap;
        full  = (wr_ptr == rd_ptr) && wrap;

        // Slot frees only once memory has taken the store.
        pop = busy && out_queue && dmem_rsp.ready;

        issue_head = !empty && !busy;
        bypass     = op_store && empty && !busy;
        push       = op_store && !bypass && (!full || pop);
        issue_op   = op_order && empty && !busy;

        op_done = bypass || push || issue_op;
        issue   = issue_head || bypass || issue_op;
    end

    // Store acks are registered, load and fence data come straight through.
    always_comb begin
        core_rsp.ready = store_ack || (out_core && dmem_rsp.ready);
        core_rsp.rdata = (out_core && dmem_rsp.ready) ? dmem_rsp.rdata : 32'h0;
    end

    assign dmem_req = dmem_q;

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            wrap      <= 1'b0;
            busy      <= 1'b0;
            out_queue <= 1'b0;
            out_core  <= 1'b0;
            store_ack <= 1'b0;
            hold      <= '0;
            dmem_q    <= '0;
        end else begin
            store_ack <= bypass || push;

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Both pointers wrapping in one cycle cancel out.
            wrap <= wrap ^ (push && wr_ptr == '1) ^ (pop && rd_ptr == '1);

            hold <= op;
            if (op_done) begin
                hold.valid <= 1'b0;
            end

            dmem_q.valid <= 1'b0;                  // One-cycle request pulse.
            if (issue_head) begin
                dmem_q.valid <= 1'b1;
                dmem_q.fence <= 1'b0;
                dmem_q.addr  <= queue[rd_ptr].addr;
                dmem_q.wdata <= queue[rd_ptr].wdata;
                dmem_q.wstrb <= queue[rd_ptr].wstrb;
            end else if (bypass || issue_op) begin
                dmem_q <= op;
            end

            if (issue) begin
                busy      <= 1'b1;
                out_queue <= issue_head;
                out_core  <= issue_op;
            end else if (dmem_rsp.ready) begin
                busy      <= 1'b0;
                out_queue <= 1'b0;
                out_core  <= 1'b0;
            end
        end
    end

    // Slot storage.
    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr].wstrb <= op.wstrb;
            queue[wr_ptr].addr  <= op.addr;
            queue[wr_ptr].wdata <= op.wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/bank_router.sv
`default_nettype none

module bank_router (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t dmem_req,
    input  logic              dmem_ready,
    output mem_pkg::mem_req_t bank_req [mem_pkg::NUM_BANKS],
    output logic              fence_pend
);

    logic [mem_pkg::BANK_BITS-1:0] sel;

    assign sel = dmem_req.addr[mem_pkg::BANK_LSB +: mem_pkg::BANK_BITS];

    // ------------------------------------------------------------
    // Request steering
    // ------------------------------------------------------------

    // Payload fans out to all banks, valid only to the addressed one.
    always_comb begin
        for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
            bank_req[b]       = dmem_req;
            bank_req[b].valid = dmem_req.valid &&
                                (dmem_req.fence || sel == mem_pkg::BANK_BITS'(b));
        end
    end

    // ------------------------------------------------------------
    // Fence tracking
    // ------------------------------------------------------------

    // Tells the merger to collect acks instead of forwarding data.
    always_ff @(posedge clk) begin
        if (!rst) begin
            fence_pend <= 1'b0;
        end else if (dmem_req.valid && dmem_req.fence) begin
            fence_pend <= 1'b1;
        end else if (dmem_ready) begin
            fence_pend <= 1'b0;            // Merged ack has gone out.
        end
    end

endmodule

`default_nettype wire

//--- design/sram_bank.sv
`default_nettype none

module sram_bank (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::mem_rsp_t rsp
);

    logic [31:0] mem [mem_pkg::BANK_WORDS];

    logic [mem_pkg::BANK_WORDS_LOG2-1:0] index;
    logic                                is_load;

    logic [mem_pkg::BANK_LATENCY-1:0] ready_pipe;
    logic [31:0]                      data_pipe [mem_pkg::BANK_LATENCY];

    // Word index starts right above the bank select bits.
    assign index   = req.addr[mem_pkg::BANK_LSB + mem_pkg::BANK_BITS +: mem_pkg::BANK_WORDS_LOG2];
    assign is_load = req.valid && !req.fence && (req.wstrb == 4'b0000);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (req.valid && !req.fence) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[index][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Response pipeline
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready_pipe <= '0;
        end else begin
            ready_pipe <= {ready_pipe[mem_pkg::BANK_LATENCY-2:0], req.valid};
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= is_load ? mem[index] : 32'h0;     // Stores and fences return zero.
        for (int s = 1; s < mem_pkg::BANK_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
        end
    end

    assign rsp.ready = ready_pipe[mem_pkg::BANK_LATENCY-1];
    assign rsp.rdata = data_pipe[mem_pkg::BANK_LATENCY-1];

endmodule

`default_nettype wire

//--- design/resp_merge.sv
`default_nettype none

module resp_merge (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_rsp_t bank_rsp [mem_pkg::NUM_BANKS],
    input  logic              fence_pend,
    output mem_pkg::mem_rsp_t dmem_rsp
);

    logic [mem_pkg::NUM_BANKS-1:0] hit;
    logic [mem_pkg::NUM_BANKS-1:0] acks;
    logic [mem_pkg::NUM_BANKS-1:0] acks_q;     // Sticky fence acks.
    logic [31:0]                   data;

    always_comb begin
        data = 32'h0;
        for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
            hit[b] = bank_rsp[b].ready;
            data   = data | (bank_rsp[b].rdata & {32{hit[b]}});   // One-hot mux.
        end
        acks = acks_q | hit;

        if (fence_pend) begin
            dmem_rsp.ready = &acks;
            dmem_rsp.rdata = 32'h0;
        end else begin
            dmem_rsp.ready = |hit;
            dmem_rsp.rdata = data;
        end
    end

    // Cleared once the merged fence ack has pulsed.
    always_ff @(posedge clk) begin
        if (!rst) begin
            acks_q <= '0;
        end else if (fence_pend && !(&acks)) begin
            acks_q <= acks;
        end else begin
            acks_q <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/data_mem_top.sv
`default_nettype none

module data_mem_top (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t core_req,
    output mem_pkg::mem_rsp_t core_rsp
);

    mem_pkg::mem_req_t dmem_req;
    mem_pkg::mem_rsp_t dmem_rsp;
    mem_pkg::mem_req_t bank_req [mem_pkg::NUM_BANKS];
    mem_pkg::mem_rsp_t bank_rsp [mem_pkg::NUM_BANKS];
    logic              fence_pend;

    write_buffer u_write_buffer (
        .clk      (clk),
        .rst      (rst),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    bank_router u_bank_router (
        .clk        (clk),
        .rst        (rst),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_rsp.ready),
        .bank_req   (bank_req),
        .fence_pend (fence_pend)
    );

    // Word-interleaved banks.
    for (genvar i = 0; i < mem_pkg::NUM_BANKS; i++) begin : g_bank
        sram_bank u_sram_bank (
            .clk (clk),
            .rst (rst),
            .req (bank_req[i]),
            .rsp (bank_rsp[i])
        );
    end

    resp_merge u_resp_merge (
        .clk        (clk),
        .rst        (rst),
        .bank_rsp   (bank_rsp),
        .fence_pend (fence_pend),
        .dmem_rsp   (dmem_rsp)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // Period of 10.
    end

    // Active low for the first three rising edges.
    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/data_mem_tb.sv
`default_nettype none

module data_mem_tb;

    localparam logic [1:0] OP_STORE = 2'd0;
    localparam logic [1:0] OP_LOAD  = 2'd1;
    localparam logic [1:0] OP_FENCE = 2'd2;
    localparam int RAND_OPS = 60;
    localparam int SHADOW_WORDS = mem_pkg::NUM_BANKS * mem_pkg::BANK_WORDS;
    localparam int BURST_LEN = 2 * mem_pkg::WB_DEPTH + 2;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
    } op_entry_t;

    logic              clk;
    logic              rst;
    mem_pkg::mem_req_t core_req;
    mem_pkg::mem_rsp_t core_rsp;

    op_entry_t   table_q [$];
    logic [31:0] shadow [SHADOW_WORDS];
    logic        written [SHADOW_WORDS];
    logic [31:0] lfsr;
    logic        table_built;
    int          pass_count;
    int          fail_count;
    int          test_num;
    int          since_drain;                   // Stores since the last load or fence.
    int          stalled_stores;                // Stores that waited for a free slot.

    tb_clock u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    data_mem_top uut (
        .clk      (clk),
        .rst      (rst),
        .core_req (core_req),
        .core_rsp (core_rsp)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic add_op(input logic [1:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb,
                          input logic [31:0] exp_rdata);
        op_entry_t e;
        e.op        = op;
        e.addr      = addr;
        e.wdata     = wdata;
        e.wstrb     = wstrb;
        e.exp_rdata = exp_rdata;
        table_q.push_back(e);
    endtask

    // Only strobed bytes change.
    task automatic update_shadow(input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [3:0] wstrb);
        int w;
        w = addr[9:2];
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                shadow[w][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        written[w] = 1'b1;
    endtask

    task automatic report_test(input logic ok, input string what);
        test_num++;
        if (ok) begin
            pass_count++;
            $display("[PASS] test %0d: %s", test_num, what);
        end else begin
            fail_count++;
            $display("[FAIL] test %0d: %s", test_num, what);
        end
    endtask

    task automatic run_op(input op_entry_t e);
        int   cycles;
        logic ok;
        ok     = 1'b1;
        cycles = 1;
        @(posedge clk);
        core_req.valid <= 1'b1;
        core_req.fence <= (e.op == OP_FENCE);
        core_req.addr  <= e.addr;
        core_req.wdata <= e.wdata;
        core_req.wstrb <= (e.op == OP_STORE) ? e.wstrb : 4'b0000;
        @(posedge clk);
        core_req.valid <= 1'b0;                 // One cycle per operation.
        @(negedge clk);
        while (core_rsp.ready !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        if (core_rsp.rdata !== e.exp_rdata) begin
            $display("[ERROR] %0t core_rsp.rdata expected %08h got %08h",
                     $time, e.exp_rdata, core_rsp.rdata);
            ok = 1'b0;
        end
        if (e.op == OP_STORE && since_drain < mem_pkg::WB_DEPTH && cycles != 1) begin
            $display("Store to %08h was acknowledged after %0d cycles with slots free",
                     e.addr, cycles);
            ok = 1'b0;
        end
        if (e.op == OP_STORE && cycles > 1) begin
            stalled_stores++;
        end
        if (e.op == OP_STORE) begin
            since_drain++;
            update_shadow(e.addr, e.wdata, e.wstrb);
        end else begin
            since_drain = 0;
        end
        report_test(ok, $sformatf("op %0d addr %08h rdata %08h after %0d cycles",
                                  e.op, e.addr, core_rsp.rdata, cycles));
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        logic [31:0]        r;
        int                 word;
        logic               ok;
        op_entry_t          e;
        mem_pkg::wb_entry_t st;

        core_req       = '0;
        lfsr           = 32'he36f;
        table_built    = 1'b0;
        pass_count     = 0;
        fail_count     = 0;
        test_num       = 0;
        since_drain    = 0;
        stalled_stores = 0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            written[i] = 1'b0;
        end

        add_op(OP_STORE, 32'h000, 32'h1122_3344, 4'b1111, 32'h0);
        add_op(OP_LOAD,  32'h000, 32'h0, 4'b0000, 32'h1122_3344);
        // Bytes merge into one word.
        add_op(OP_STORE, 32'h004, 32'hAAAA_AAAA, 4'b1111, 32'h0);
        add_op(OP_STORE, 32'h004, 32'h0000_00BB, 4'b0001, 32'h0);
        add_op(OP_STORE, 32'h004, 32'hCC00_0000, 4'b1000, 32'h0);
        add_op(OP_STORE, 32'h004, 32'h00DD_0000, 4'b0100, 32'h0);
        add_op(OP_LOAD,  32'h004, 32'h0, 4'b0000, 32'hCCDD_AABB);
        // Burst long enough to fill the buffer, read back over all banks.
        for (int i = 0; i < BURST_LEN; i++) begin
            add_op(OP_STORE, 32'h100 + 4 * i, 32'hB000_0000 + i, 4'b1111, 32'h0);
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            add_op(OP_LOAD, 32'h100 + 4 * i, 32'h0, 4'b0000, 32'hB000_0000 + i);
        end
        // Same bank, different word index.
        add_op(OP_STORE, 32'h020, 32'hDEAD_BEEF, 4'b1111, 32'h0);
        add_op(OP_STORE, 32'h010, 32'h0BAD_F00D, 4'b1111, 32'h0);
        add_op(OP_LOAD,  32'h000, 32'h0, 4'b0000, 32'h1122_3344);
        add_op(OP_LOAD,  32'h010, 32'h0, 4'b0000, 32'h0BAD_F00D);
        add_op(OP_LOAD,  32'h020, 32'h0, 4'b0000, 32'hDEAD_BEEF);
        for (int i = 0; i < 3; i++) begin
            add_op(OP_STORE, 32'h300 + 4 * i, 32'h0101_0101 * (i + 1), 4'b1111, 32'h0);
        end
        add_op(OP_FENCE, 32'h0, 32'h0, 4'b0000, 32'h0);
        for (int i = 0; i < 3; i++) begin
            add_op(OP_LOAD, 32'h300 + 4 * i, 32'h0, 4'b0000, 32'h0101_0101 * (i + 1));
        end
        table_built = 1'b1;

        // No request yet, so no ready.
        wait (rst === 1'b1);
        ok = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (core_rsp.ready !== 1'b0) begin
                $display("core_rsp.ready rose at %0t before any request", $time);
                ok = 1'b0;
            end
        end
        report_test(ok, "core ready idle after reset");

        foreach (table_q[i]) begin
            run_op(table_q[i]);
        end

        // The burst outruns the drain, so some store has to wait.
        ok = 1'b1;
        if (stalled_stores == 0) begin
            $display("No store in the burst was held back by a full buffer");
            ok = 1'b0;
        end
        report_test(ok, "store back-pressure on a full buffer");

        // Random stores and loads over the low 32 words.
        for (int n = 0; n < RAND_OPS; n++) begin
            draw_bits(5, r);
            word    = r[4:0];
            st.addr = word << 2;
            draw_bits(1, r);
            if (r[0] && written[word]) begin
                e.op        = OP_LOAD;
                e.addr      = st.addr;
                e.wdata     = 32'h0;
                e.wstrb     = 4'b0000;
                e.exp_rdata = shadow[word];
            end else begin
                draw_bits(32, r);
                st.wdata = r;
                draw_bits(4, r);
                st.wstrb = r[3:0];
                if (st.wstrb == 4'b0000 || !written[word]) begin
                    st.wstrb = 4'b1111;     // Unwritten words get a full store first.
                end
                e.op        = OP_STORE;
                e.addr      = st.addr;
                e.wdata     = st.wdata;
                e.wstrb     = st.wstrb;
                e.exp_rdata = 32'h0;
            end
            run_op(e);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------

    initial begin : watchdog
        int limit;
        wait (table_built === 1'b1);
        limit = (table_q.size() + RAND_OPS) * (mem_pkg::WB_DEPTH + 1)
                * (mem_pkg::BANK_LATENCY + 2) + 20;
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles waiting for core_rsp.ready", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- data_mem_top.f
design/mem_pkg.sv
design/write_buffer.sv
design/bank_router.sv
design/sram_bank.sv
design/resp_merge.sv
design/data_mem_top.sv
tb/tb_clock.sv
tb/data_mem_tb.sv

//--- Bender.yml
package:
  name: data_mem

sources:
  # Design, in compile order.
  - files:
      - design/mem_pkg.sv
      - design/write_buffer.sv
      - design/bank_router.sv
      - design/sram_bank.sv
      - design/resp_merge.sv
      - design/data_mem_top.sv

  # Testbench, top module data_mem_tb.
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/data_mem_tb.sv
